//--- search_top.f
rtl/search_pkg.sv
rtl/query_decode.sv
rtl/distance_unit.sv
rtl/topk_queue.sv
rtl/result_drain.sv
rtl/search_top.sv
testbench/search_checker.sv
testbench/search_tb.sv

//--- Makefile
# Verilator build and run of the search core testbench

VERILATOR ?= verilator
TOP       ?= search_tb
FILELIST  ?= search_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/search_tb.sv
`timescale 1ns/1ps

module search_tb
  import search_pkg::*;
();

  localparam int DIM = 4;
  localparam int PQ_LENGTH = 5;
  localparam int IN_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  localparam int IDX_W = $clog2(DIM);
  localparam int NUM_TESTS = 9;
  localparam int MAX_CANDS = 16;

  logic             clk_100mhz = 1'b0;
  logic             sys_rst;
  logic             in_valid;
  op_t              in_op;
  logic [IDX_W-1:0] in_index;
  coord_t           in_data;
  vertex_id_t       in_id;
  logic             in_credit;
  logic             res_valid;
  vertex_id_t       res_id;
  dist_t            res_dist;
  logic             res_last;
  logic             out_credit;

  // stimulus table with one row per query
  string tab_name      [NUM_TESTS];
  int    tab_qbase     [NUM_TESTS];
  int    tab_count     [NUM_TESTS];
  int    tab_k         [NUM_TESTS];
  bit    tab_tie       [NUM_TESTS];
  bit    tab_throttle  [NUM_TESTS];
  bit    tab_reuse     [NUM_TESTS];
  int    tab_exp_beats [NUM_TESTS];
  int    tab_first     [NUM_TESTS];
  int    rcv_count     [NUM_TESTS];
  int    n_tests;

  // current query and candidate set
  coord_t     query_c [DIM];
  coord_t     cand_c  [MAX_CANDS][DIM];
  vertex_id_t cand_ids [MAX_CANDS];

  // words waiting for an input credit
  op_t              word_op[$];
  logic [IDX_W-1:0] word_index[$];
  coord_t           word_data[$];
  vertex_id_t       word_id[$];

  // predicted beats, in answer order
  longint exp_ids[$];
  longint exp_dists[$];
  longint exp_last[$];
  int     exp_test[$];
  int     exp_total;

  longint rcv_ids[$];
  longint rcv_dists[$];
  int     rcv_total;

  // sink credit return times
  int due_cycles[$];
  int cycle_count;
  int host_credits;
  int seed;
  bit table_ready;

  search_top #(
    .DIM(DIM),
    .PQ_LENGTH(PQ_LENGTH),
    .IN_DEPTH(IN_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) dut0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_index(in_index),
    .in_data(in_data),
    .in_id(in_id),
    .in_credit(in_credit),
    .res_valid(res_valid),
    .res_id(res_id),
    .res_dist(res_dist),
    .res_last(res_last),
    .out_credit(out_credit)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input longint expected, input longint actual);
    if (expected != actual) begin
      $display("Fail %s %s: expected %0d, actual %0d", test, what, expected, actual);
      fail_run("value mismatch");
    end
  endtask

  task automatic add_entry(input string name, input int qbase, input int count, input int k,
                           input bit tie, input bit throttle, input bit reuse, input int beats);
    tab_name[n_tests]      = name;
    tab_qbase[n_tests]     = qbase;
    tab_count[n_tests]     = count;
    tab_k[n_tests]         = k;
    tab_tie[n_tests]       = tie;
    tab_throttle[n_tests]  = throttle;
    tab_reuse[n_tests]     = reuse;
    tab_exp_beats[n_tests] = beats;
    n_tests = n_tests + 1;
  endtask

  // name, query base, candidates, k, tie, throttle, reuse, beats
  task automatic load_table();
    n_tests = 0;
    add_entry("reset_end_only",   0,     0,  3, 0, 0, 0, 0);
    add_entry("random_k3",        1000,  8,  3, 0, 0, 0, 3);
    add_entry("random_full",      30000, 12, 5, 0, 0, 0, 5);
    add_entry("throttled_repeat", 30000, 12, 5, 0, 1, 1, 5);
    add_entry("tie_overflow",     100,   8,  5, 1, 0, 0, 5);
    add_entry("k_above_len",      5000,  7,  9, 0, 0, 0, 5);
    add_entry("few_cands",        7000,  2,  4, 0, 0, 0, 2);
    add_entry("k_zero",           9000,  4,  0, 0, 0, 0, 1);
    add_entry("throttled_tie",    200,   9,  4, 1, 1, 0, 4);
  endtask

  task automatic push_word(input op_t op, input int idx, input coord_t data,
                           input vertex_id_t id);
    word_op.push_back(op);
    word_index.push_back(IDX_W'(idx));
    word_data.push_back(data);
    word_id.push_back(id);
  endtask

  // reference model sorts stably by squared distance
  task automatic predict_answer(input int e);
    longint d [MAX_CANDS];
    int     order [MAX_CANDS];
    longint diff;
    int     kk;
    int     n;
    int     j;
    int     tmp;
    for (int i = 0; i < tab_count[e]; i++) begin
      d[i] = 0;
      for (int c = 0; c < DIM; c++) begin
        diff = longint'(cand_c[i][c]) - longint'(query_c[c]);
        d[i] = d[i] + diff * diff;
      end
      order[i] = i;
    end
    // only a strictly greater distance moves back so ties keep arrival order
    for (int i = 1; i < tab_count[e]; i++) begin
      j = i;
      while (j > 0 && d[order[j-1]] > d[order[j]]) begin
        tmp = order[j];
        order[j] = order[j-1];
        order[j-1] = tmp;
        j = j - 1;
      end
    end
    kk = (tab_k[e] < 1) ? 1 : ((tab_k[e] > PQ_LENGTH) ? PQ_LENGTH : tab_k[e]);
    n = (kk < tab_count[e]) ? kk : tab_count[e];
    tab_first[e] = exp_total;
    for (int b = 0; b < n; b++) begin
      exp_ids.push_back(longint'(cand_ids[order[b]]));
      exp_dists.push_back(d[order[b]]);
      exp_last.push_back((b == n - 1) ? 1 : 0);
      exp_test.push_back(e);
    end
    exp_total = exp_total + n;
  endtask

  task automatic send_query(input int e);
    for (int c = 0; c < DIM; c++) begin
      query_c[c] = coord_t'(tab_qbase[e] + 1000 * c);
      push_word(op_query, c, query_c[c], '0);
    end
    // a repeat row keeps the previous candidate set
    if (!tab_reuse[e]) begin
      for (int i = 0; i < tab_count[e]; i++) begin
        cand_ids[i] = vertex_id_t'(e * 100 + i);
        for (int c = 0; c < DIM; c++) begin
          if (tab_tie[e]) begin
            // distances 0, 1, 4 repeating
            cand_c[i][c] = (c == 0) ? query_c[c] + coord_t'(i % 3) : query_c[c];
          end else begin
            cand_c[i][c] = coord_t'($random(seed));
          end
        end
      end
    end
    for (int i = 0; i < tab_count[e]; i++) begin
      for (int c = 0; c < DIM; c++) begin
        push_word(op_vertex, c, cand_c[i][c], cand_ids[i]);
      end
    end
    push_word(op_end, 0, coord_t'(tab_k[e]), '0);
    predict_answer(e);
  endtask

  // sink checks each beat and schedules its credit
  task automatic take_beat();
    int    delay;
    string name;
    if (exp_ids.size() == 0) begin
      fail_run("a result beat arrived with no answer pending");
    end else begin
      name = tab_name[exp_test[0]];
      check_value(name, "res_id", exp_ids[0], longint'(res_id));
      check_value(name, "res_dist", exp_dists[0], longint'(res_dist));
      check_value(name, "res_last", exp_last[0], longint'(res_last));
      delay = 1;
      if (tab_throttle[exp_test[0]]) begin
        delay = 5 + int'($unsigned($random(seed)) % 20);
      end
      due_cycles.push_back(cycle_count + delay);
      rcv_ids.push_back(longint'(res_id));
      rcv_dists.push_back(longint'(res_dist));
      rcv_count[exp_test[0]] = rcv_count[exp_test[0]] + 1;
      rcv_total = rcv_total + 1;
      void'(exp_ids.pop_front());
      void'(exp_dists.pop_front());
      void'(exp_last.pop_front());
      void'(exp_test.pop_front());
    end
  endtask

  // at most one credit pulse per cycle
  task automatic return_credit();
    out_credit = 1'b0;
    if (due_cycles.size() != 0 && due_cycles[0] <= cycle_count) begin
      void'(due_cycles.pop_front());
      out_credit = 1'b1;
    end
  endtask

  task automatic drive_word();
    if (word_op.size() != 0 && host_credits > 0) begin
      in_valid = 1'b1;
      in_op    = word_op.pop_front();
      in_index = word_index.pop_front();
      in_data  = word_data.pop_front();
      in_id    = word_id.pop_front();
      host_credits = host_credits - 1;
    end else begin
      in_valid = 1'b0;
    end
  endtask

  // all channel traffic on the falling edge
  always @(negedge clk_100mhz) begin
    cycle_count = cycle_count + 1;
    if (in_credit) begin
      host_credits = host_credits + 1;
      if (host_credits > IN_DEPTH) begin
        fail_run("decode returned more input credits than the host spent");
      end
    end
    if (res_valid) begin
      take_beat();
    end
    return_credit();
    drive_word();
  end

  // budget from table length and candidate count
  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 0;
    for (int e = 0; e < n_tests; e++) begin
      limit = limit + 200 + 20 * tab_count[e];
    end
    repeat (limit) @(posedge clk_100mhz);
    fail_run("watchdog expired, the run hung");
  end

  initial begin : main_flow
    sys_rst     = 1'b1;
    in_valid    = 1'b0;
    in_op       = op_query;
    in_index    = '0;
    in_data     = '0;
    in_id       = '0;
    out_credit  = 1'b0;
    seed        = 62122;
    cycle_count = 0;
    host_credits = IN_DEPTH;
    exp_total   = 0;
    rcv_total   = 0;
    for (int e = 0; e < NUM_TESTS; e++) begin
      rcv_count[e] = 0;
    end
    load_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk_100mhz);
    sys_rst = 1'b0;
    @(negedge clk_100mhz);
    check_value(tab_name[0], "res_valid", 0, longint'(res_valid));
    check_value(tab_name[0], "in_credit", 0, longint'(in_credit));
    // end only query must stay silent for 20 cycles
    @(posedge clk_100mhz);
    send_query(0);
    while (word_op.size() != 0 || host_credits != IN_DEPTH) begin
      @(negedge clk_100mhz);
    end
    repeat (20) @(negedge clk_100mhz);
    // remaining rows back to back
    @(posedge clk_100mhz);
    for (int e = 1; e < n_tests; e++) begin
      send_query(e);
    end
    while (rcv_total != exp_total || due_cycles.size() != 0 || word_op.size() != 0) begin
      @(negedge clk_100mhz);
    end
    // stray beats would fail in the sink
    repeat (20) @(negedge clk_100mhz);
    for (int e = 0; e < n_tests; e++) begin
      check_value(tab_name[e], "beat_count", tab_exp_beats[e], rcv_count[e]);
      if (tab_reuse[e]) begin
        // throttled run must match the free running one
        for (int b = 0; b < rcv_count[e]; b++) begin
          check_value(tab_name[e], "repeat_id",
                      rcv_ids[tab_first[e-1] + b], rcv_ids[tab_first[e] + b]);
          check_value(tab_name[e], "repeat_dist",
                      rcv_dists[tab_first[e-1] + b], rcv_dists[tab_first[e] + b]);
        end
      end
    end
    check_value("final", "host_credits", IN_DEPTH, host_credits);
    $display("TEST OK");
    $finish;
  end

endmodule

//--- testbench/search_checker.sv
`timescale 1ns/1ps

// credit and buffer rules bound into drain and decode
// level is the design's own count of what is left
// spend uses one up and refill gives one back
module search_checker #(
  parameter int LIMIT = 2
) (
  input logic       clk_100mhz,
  input logic       sys_rst,
  input logic [7:0] level,
  input logic       spend,
  input logic       refill
);

  // independent count, starts full after reset
  logic [7:0] avail;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      avail <= 8'(LIMIT);
    end else begin
      avail <= avail - 8'(spend) + 8'(refill);
    end
  end

  // count never above its ceiling
  level_in_range: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) level <= 8'(LIMIT)
  ) else $error("count %0d above limit %0d", level, LIMIT);

  // no beat once everything is used up
  spend_allowed: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) spend |-> (avail != 8'd0)
  ) else $error("beat issued with nothing left");

  // design count follows spends and refills
  level_tracks: assert property (
    @(posedge clk_100mhz) disable iff (sys_rst) level == avail
  ) else $error("count %0d where %0d was expected", level, avail);

endmodule

// drain credits start at OUT_CREDITS and each res_valid spends one
bind result_drain search_checker #(
  .LIMIT(OUT_CREDITS)
) drain_chk (
  .clk_100mhz(clk_100mhz),
  .sys_rst(sys_rst),
  .level(8'(credits)),
  .spend(res_valid),
  .refill(out_credit)
);

// decode free slots, a write takes one and a pop frees one
bind query_decode search_checker #(
  .LIMIT(IN_DEPTH)
) decode_chk (
  .clk_100mhz(clk_100mhz),
  .sys_rst(sys_rst),
  .level(8'(IN_DEPTH - buf_count)),
  .spend(in_valid),
  .refill(pop)
);

//--- rtl/search_top.sv
`timescale 1ns/1ps

module search_top
  import search_pkg::*;
#(
  parameter int DIM = 4,
  parameter int PQ_LENGTH = 5,
  parameter int IN_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                   clk_100mhz,
  input  logic                   sys_rst,
  // input channel
  input  logic                   in_valid,
  input  op_t                    in_op,
  input  logic [$clog2(DIM)-1:0] in_index,
  input  coord_t                 in_data,
  input  vertex_id_t             in_id,
  output logic                   in_credit,
  // output channel
  output logic                   res_valid,
  output vertex_id_t             res_id,
  output dist_t                  res_dist,
  output logic                   res_last,
  input  logic                   out_credit
);

  localparam int CNT_W = $clog2(PQ_LENGTH + 1);

  // decode to execute
  logic             cand_valid;
  vertex_id_t       cand_id;
  coord_t [DIM-1:0] cand_coords;
  coord_t [DIM-1:0] query_coords;
  logic             cand_end;
  k_t               cand_k;

  // execute to queue and drain
  logic       dist_valid;
  vertex_id_t dist_id;
  dist_t      dist_value;
  logic       dist_end;
  k_t         dist_k;

  // queue contents
  vertex_id_t [PQ_LENGTH-1:0] q_ids;
  dist_t [PQ_LENGTH-1:0]      q_dists;
  logic [CNT_W-1:0]           q_count;

  logic drain_busy;
  logic q_clear;

  query_decode #(
    .DIM(DIM),
    .PQ_LENGTH(PQ_LENGTH),
    .IN_DEPTH(IN_DEPTH)
  ) decode0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .in_valid(in_valid),
    .in_op(in_op),
    .in_index(in_index),
    .in_data(in_data),
    .in_id(in_id),
    .drain_busy(drain_busy),
    .in_credit(in_credit),
    .cand_valid(cand_valid),
    .cand_id(cand_id),
    .cand_coords(cand_coords),
    .query_coords(query_coords),
    .cand_end(cand_end),
    .cand_k(cand_k)
  );

  distance_unit #(
    .DIM(DIM)
  ) exec0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .cand_valid(cand_valid),
    .cand_id(cand_id),
    .cand_coords(cand_coords),
    .query_coords(query_coords),
    .cand_end(cand_end),
    .cand_k(cand_k),
    .dist_valid(dist_valid),
    .dist_id(dist_id),
    .dist_value(dist_value),
    .dist_end(dist_end),
    .dist_k(dist_k)
  );

  // end markers never enter the queue
  topk_queue #(
    .PQ_LENGTH(PQ_LENGTH)
  ) queue0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .ins_valid(dist_valid && !dist_end),
    .ins_id(dist_id),
    .ins_dist(dist_value),
    .q_clear(q_clear),
    .q_ids(q_ids),
    .q_dists(q_dists),
    .q_count(q_count)
  );

  result_drain #(
    .PQ_LENGTH(PQ_LENGTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) drain0 (
    .clk_100mhz(clk_100mhz),
    .sys_rst(sys_rst),
    .dist_valid(dist_valid),
    .dist_end(dist_end),
    .dist_k(dist_k),
    .q_ids(q_ids),
    .q_dists(q_dists),
    .q_count(q_count),
    .out_credit(out_credit),
    .res_valid(res_valid),
    .res_id(res_id),
    .res_dist(res_dist),
    .res_last(res_last),
    .drain_busy(drain_busy),
    .q_clear(q_clear)
  );

endmodule

//--- rtl/result_drain.sv
`timescale 1ns/1ps

module result_drain
  import search_pkg::*;
#(
  parameter int PQ_LENGTH = 5,
  parameter int OUT_CREDITS = 2
) (
  input  logic                             clk_100mhz,
  input  logic                             sys_rst,
  input  logic                             dist_valid,
  input  logic                             dist_end,
  input  k_t                               dist_k,
  input  vertex_id_t [PQ_LENGTH-1:0]       q_ids,
  input  dist_t [PQ_LENGTH-1:0]            q_dists,
  input  logic [$clog2(PQ_LENGTH+1)-1:0]   q_count,
  input  logic                             out_credit,
  output logic                             res_valid,
  output vertex_id_t                       res_id,
  output dist_t                            res_dist,
  output logic                             res_last,
  output logic                             drain_busy,
  output logic                             q_clear
);

  localparam int CRED_W = $clog2(OUT_CREDITS + 1);
  localparam int IDX_W = $clog2(PQ_LENGTH);

  typedef enum logic [1:0] {
    idle,
    emit,
    done
  } drain_state_t;

  drain_state_t      state;
  k_t                beats_left;
  logic [IDX_W-1:0]  rd_idx;
  logic [CRED_W-1:0] credits;

  // answer length, min of k and fill
  k_t fill_k;
  k_t take_k;

  assign fill_k = k_t'(q_count);
  assign take_k = (dist_k < fill_k) ? dist_k : fill_k;

  // beat goes out the same cycle a credit is available
  assign res_valid = (state == emit) && (beats_left != '0) && (credits != '0);
  assign res_last  = res_valid && (beats_left == k_t'(1));
  assign res_id    = q_ids[rd_idx];
  assign res_dist  = q_dists[rd_idx];

  // holds decode off while the queue is read
  assign drain_busy = (state != idle);
  assign q_clear    = (state == done);

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      state      <= idle;
      beats_left <= '0;
      rd_idx     <= '0;
      credits    <= CRED_W'(OUT_CREDITS);
    end else begin
      // spend on a beat, refill on a sink return
      credits <= credits - CRED_W'(res_valid) + CRED_W'(out_credit);
      case (state)
        idle: begin
          rd_idx <= '0;
          if (dist_valid && dist_end) begin
            beats_left <= take_k;
            state      <= emit;
          end
        end
        emit: begin
          if (res_valid) begin
            beats_left <= beats_left - 1'b1;
            // stay on the final slot, never index past the queue
            if (!res_last) begin
              rd_idx <= rd_idx + 1'b1;
            end
          end
          // empty answer skips straight to done
          if (beats_left == '0 || res_last) begin
            state <= done;
          end
        end
        done: begin
          // q_clear is high this cycle
          state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

//--- rtl/topk_queue.sv
`timescale 1ns/1ps

module topk_queue
  import search_pkg::*;
#(
  parameter int PQ_LENGTH = 5
) (
  input  logic                             clk_100mhz,
  input  logic                             sys_rst,
  input  logic                             ins_valid,
  input  vertex_id_t                       ins_id,
  input  dist_t                            ins_dist,
  input  logic                             q_clear,
  output vertex_id_t [PQ_LENGTH-1:0]       q_ids,
  output dist_t [PQ_LENGTH-1:0]            q_dists,
  output logic [$clog2(PQ_LENGTH+1)-1:0]   q_count
);

  localparam int CNT_W = $clog2(PQ_LENGTH + 1);

  // slot for the new entry
  // PQ_LENGTH means worse than a full queue
  logic [CNT_W-1:0] ins_pos;
  logic             ins_take;

  // entries are sorted, so counting the ones <= new gives the slot
  // equal distances stay ahead, keeps arrival order on ties
  always_comb begin
    ins_pos = '0;
    for (int i = 0; i < PQ_LENGTH; i++) begin
      if (CNT_W'(i) < q_count && q_dists[i] <= ins_dist) begin
        ins_pos = ins_pos + 1'b1;
      end
    end
  end

  assign ins_take = ins_valid && (ins_pos != CNT_W'(PQ_LENGTH));

  // entry storage
  always_ff @(posedge clk_100mhz) begin
    if (ins_take) begin
      // shift the tail down one slot, last entry falls off
      for (int i = PQ_LENGTH - 1; i > 0; i--) begin
        if (CNT_W'(i) > ins_pos) begin
          q_ids[i]   <= q_ids[i-1];
          q_dists[i] <= q_dists[i-1];
        end
      end
      q_ids[ins_pos]   <= ins_id;
      q_dists[ins_pos] <= ins_dist;
    end
  end

  // fill count
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      q_count <= '0;
    end else if (q_clear) begin
      // drain finished, start the next query empty
      q_count <= '0;
    end else if (ins_take && q_count != CNT_W'(PQ_LENGTH)) begin
      q_count <= q_count + 1'b1;
    end
  end

endmodule

//--- rtl/distance_unit.sv
`timescale 1ns/1ps

module distance_unit
  import search_pkg::*;
#(
  parameter int DIM = 4
) (
  input  logic             clk_100mhz,
  input  logic             sys_rst,
  input  logic             cand_valid,
  input  vertex_id_t       cand_id,
  input  coord_t [DIM-1:0] cand_coords,
  input  coord_t [DIM-1:0] query_coords,
  input  logic             cand_end,
  input  k_t               cand_k,
  output logic             dist_valid,
  output vertex_id_t       dist_id,
  output dist_t            dist_value,
  output logic             dist_end,
  output k_t               dist_k
);

  // stage one, per coordinate absolute difference
  coord_t [DIM-1:0] s1_diff;
  vertex_id_t       s1_id;
  k_t               s1_k;
  logic             s1_valid;
  logic             s1_end;

  // stage two input, sum of squares
  dist_t sum_sq;

  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < DIM; i++) begin
      if (cand_coords[i] >= query_coords[i]) begin
        s1_diff[i] <= cand_coords[i] - query_coords[i];
      end else begin
        s1_diff[i] <= query_coords[i] - cand_coords[i];
      end
    end
    s1_id <= cand_id;
    s1_k  <= cand_k;
  end

  always_comb begin
    logic [2*$bits(coord_t)-1:0] sq;
    sum_sq = '0;
    for (int i = 0; i < DIM; i++) begin
      // full width product, no truncation
      sq     = s1_diff[i] * s1_diff[i];
      sum_sq = sum_sq + dist_t'(sq);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    dist_value <= sum_sq;
    dist_id    <= s1_id;
    dist_k     <= s1_k;
  end

  // sideband keeps order, end flag trails earlier candidates
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      s1_valid   <= 1'b0;
      s1_end     <= 1'b0;
      dist_valid <= 1'b0;
      dist_end   <= 1'b0;
    end else begin
      s1_valid   <= cand_valid;
      s1_end     <= cand_valid && cand_end;
      dist_valid <= s1_valid;
      dist_end   <= s1_end;
    end
  end

endmodule

//--- rtl/query_decode.sv
`timescale 1ns/1ps

module query_decode
  import search_pkg::*;
#(
  parameter int DIM = 4,
  parameter int PQ_LENGTH = 5,
  parameter int IN_DEPTH = 4
) (
  input  logic                      clk_100mhz,
  input  logic                      sys_rst,
  input  logic                      in_valid,
  input  op_t                       in_op,
  input  logic [$clog2(DIM)-1:0]    in_index,
  input  coord_t                    in_data,
  input  vertex_id_t                in_id,
  input  logic                      drain_busy,
  output logic                      in_credit,
  output logic                      cand_valid,
  output vertex_id_t                cand_id,
  output coord_t [DIM-1:0]          cand_coords,
  output coord_t [DIM-1:0]          query_coords,
  output logic                      cand_end,
  output k_t                        cand_k
);

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_DEPTH + 1);
  localparam int IDX_W = $clog2(DIM);

  // input word buffer, one slot per host credit
  op_t              buf_op    [IN_DEPTH];
  logic [IDX_W-1:0] buf_index [IN_DEPTH];
  coord_t           buf_data  [IN_DEPTH];
  vertex_id_t       buf_id    [IN_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] buf_count;

  // head of buffer
  op_t              head_op;
  logic [IDX_W-1:0] head_index;
  coord_t           head_data;
  vertex_id_t       head_id;

  logic pop;
  // set once an end word leaves, until the drain has run
  logic end_hold;
  logic busy_q;
  k_t   raw_k;
  k_t   req_k;

  assign head_op    = buf_op[rd_ptr];
  assign head_index = buf_index[rd_ptr];
  assign head_data  = buf_data[rd_ptr];
  assign head_id    = buf_id[rd_ptr];

  // words behind an end marker belong to the next query
  assign pop = (buf_count != '0) && !drain_busy && !end_hold;

  // clamp k into 1..PQ_LENGTH
  always_comb begin
    raw_k = head_data[$bits(k_t)-1:0];
    req_k = raw_k;
    if (raw_k == '0) begin
      req_k = k_t'(1);
    end else if (raw_k > k_t'(PQ_LENGTH)) begin
      req_k = k_t'(PQ_LENGTH);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (in_valid) begin
      buf_op[wr_ptr]    <= in_op;
      buf_index[wr_ptr] <= in_index;
      buf_data[wr_ptr]  <= in_data;
      buf_id[wr_ptr]    <= in_id;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      buf_count <= '0;
      in_credit <= 1'b0;
      end_hold  <= 1'b0;
      busy_q    <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      buf_count <= buf_count + CNT_W'(in_valid) - CNT_W'(pop);
      // one credit back per popped word
      in_credit <= pop;
      busy_q    <= drain_busy;
      if (pop && head_op == op_end) begin
        end_hold <= 1'b1;
      end else if (busy_q && !drain_busy) begin
        // falling edge of busy, queue already cleared
        end_hold <= 1'b0;
      end
    end
  end

  // query register and issue strobes
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      query_coords <= '0;
      cand_valid   <= 1'b0;
      cand_end     <= 1'b0;
    end else begin
      cand_valid <= 1'b0;
      cand_end   <= 1'b0;
      if (pop) begin
        case (head_op)
          op_query:  query_coords[head_index] <= head_data;
          // last coordinate completes the candidate
          op_vertex: cand_valid <= (head_index == IDX_W'(DIM - 1));
          op_end: begin
            cand_valid <= 1'b1;
            cand_end   <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // candidate assembly and end payload
  always_ff @(posedge clk_100mhz) begin
    if (pop && head_op == op_vertex) begin
      cand_coords[head_index] <= head_data;
      cand_id                 <= head_id;
    end
    if (pop && head_op == op_end) begin
      cand_k <= req_k;
    end
  end

endmodule

//--- rtl/search_pkg.sv
package search_pkg;

  // one unsigned vector coordinate
  typedef logic [15:0] coord_t;

  // vertex identifier as sent by the host
  typedef logic [15:0] vertex_id_t;

  // squared l2 distance
  // 40 bits covers DIM up to 256 at full coordinate range
  typedef logic [39:0] dist_t;

  // requested result count
  typedef logic [7:0] k_t;

  // input channel opcode
  typedef logic [1:0] op_t;

  // query coordinate at in_index
  localparam op_t op_query = 2'd0;

  // candidate coordinate at in_index, id on in_id
  localparam op_t op_vertex = 2'd1;

  // end of query, k in the low bits of in_data
  localparam op_t op_end = 2'd2;

  // code 3 is unused and ignored by decode

endpackage
